// File: design/fpu_defines.svh
// bfloat16 only (1/8/7); integer side fixed at 32 bits, so the f2i guard logic assumes 3 bits
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

//////////////////////////////
// float format
//////////////////////////////

// full bfloat16 word
`define FPU_FLOAT_DW	16
// biased exponent field
`define FPU_EXP_DW		8
// stored fraction, hidden bit not included
`define FPU_FRAC_DW		7
`define FPU_EXP_BIAS	127

//////////////////////////////
// integer side
//////////////////////////////

`define FPU_INT_DW		32
// guard, round and sticky below the integer lsb
`define FPU_F2I_GUARD	3

`endif

// File: design/fpu_pkg.sv
// types only; widths come from the defines header, opcodes outside the enum are not handled
`include "fpu_defines.svh"

package fpu_pkg;

	//////////////////////////////
	// plain vectors
	//////////////////////////////

	typedef logic [`FPU_FLOAT_DW-1:0]	float_t;
	typedef logic [`FPU_INT_DW-1:0]		int_t;
	typedef logic [`FPU_EXP_DW-1:0]		exp_t;
	typedef logic [`FPU_FRAC_DW-1:0]	frac_t;

	//////////////////////////////
	// encodings
	//////////////////////////////

	typedef enum logic [2:0]
	{
		FPU_IDLE	= 3'd0,
		FPU_EQ		= 3'd1,
		FPU_LT		= 3'd2,
		FPU_LE		= 3'd3,
		FPU_F2I		= 3'd4
	} opcode_t;

	typedef enum logic
	{
		FPU_RNDMODE_NEAREST		= 1'b0,
		FPU_RNDMODE_TRUNCATE	= 1'b1
	} rnd_mode_t;

	// one operand after split and classification
	typedef struct packed
	{
		logic	sign;
		exp_t	exp;
		frac_t	frac;
		logic	is_zero;
		logic	is_dn;
		logic	is_inf;
		logic	is_snan;
		logic	is_qnan;
	} operand_t;

	// answer of one functional unit
	typedef struct packed
	{
		logic	valid;
		int_t	value;
	} unit_res_t;

endpackage

// File: design/fpu_operand_unpack.sv
// registers both operands every cycle, so an operand is only meaningful the cycle after it is driven
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_operand_unpack
(
	input	logic					clk,
	input	logic					rst,
	input	fpu_pkg::float_t		op1_i,
	input	fpu_pkg::float_t		op2_i,
	output	fpu_pkg::operand_t		op1_operand_o,
	output	fpu_pkg::operand_t		op2_operand_o
);

	fpu_pkg::operand_t	op1_d;
	fpu_pkg::operand_t	op2_d;

	// split one word and tag its class
	function automatic fpu_pkg::operand_t unpack_word(input fpu_pkg::float_t w);
		fpu_pkg::operand_t	o;
		logic				exp_zero;
		logic				exp_ones;
		logic				frac_zero;

		o.sign		= w[`FPU_FLOAT_DW-1];
		o.exp		= w[`FPU_FRAC_DW +: `FPU_EXP_DW];
		o.frac		= w[`FPU_FRAC_DW-1:0];
		exp_zero	= (o.exp == '0);
		exp_ones	= &o.exp;
		frac_zero	= (o.frac == '0);
		o.is_zero	= exp_zero & frac_zero;
		o.is_dn		= exp_zero & ~frac_zero;
		o.is_inf	= exp_ones & frac_zero;
		// top fraction bit set means quiet
		o.is_qnan	= exp_ones & o.frac[`FPU_FRAC_DW-1];
		o.is_snan	= exp_ones & ~frac_zero & ~o.frac[`FPU_FRAC_DW-1];
		return o;
	endfunction

	always_comb
	begin
		op1_d	= unpack_word(op1_i);
		op2_d	= unpack_word(op2_i);
	end

	//////////////////////////////
	// operand registers
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			op1_operand_o	<= '0;
			op2_operand_o	<= '0;
		end
		else
		begin
			op1_operand_o	<= op1_d;
			op2_operand_o	<= op2_d;
		end
	end

endmodule

// File: design/fpu_cmp.sv
// any NaN compares false for all three opcodes; denormals are ordered by their true value
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_cmp
(
	input	logic					clk,
	input	logic					rst,
	input	logic					start_i,
	input	fpu_pkg::opcode_t		opcode_i,
	input	fpu_pkg::operand_t		op1_i,
	input	fpu_pkg::operand_t		op2_i,
	output	fpu_pkg::unit_res_t		res_o
);

	logic								any_nan;
	logic								both_zero;
	logic	[`FPU_FLOAT_DW-2:0]			mag1;
	logic	[`FPU_FLOAT_DW-2:0]			mag2;
	logic								is_eq;
	logic								is_lt;
	logic								cmp_bit;
	logic								valid_q;
	fpu_pkg::int_t						value_q;

	always_comb
	begin
		any_nan		= op1_i.is_snan | op1_i.is_qnan | op2_i.is_snan | op2_i.is_qnan;
		both_zero	= op1_i.is_zero & op2_i.is_zero;
		// exponent over fraction orders magnitudes, denormals included
		mag1		= {op1_i.exp, op1_i.frac};
		mag2		= {op2_i.exp, op2_i.frac};
		is_eq		= both_zero | ((op1_i.sign == op2_i.sign) && (mag1 == mag2));
		if (both_zero)
			is_lt	= 1'b0;
		else if (op1_i.sign != op2_i.sign)
			is_lt	= op1_i.sign;
		else if (op1_i.sign)
			is_lt	= (mag1 > mag2);
		else
			is_lt	= (mag1 < mag2);

		case (opcode_i)
			fpu_pkg::FPU_EQ:	cmp_bit = is_eq;
			fpu_pkg::FPU_LT:	cmp_bit = is_lt;
			fpu_pkg::FPU_LE:	cmp_bit = is_lt | is_eq;
			default:			cmp_bit = 1'b0;
		endcase
		if (any_nan)
			cmp_bit	= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_q	<= 1'b0;
		else
			valid_q	<= start_i;
	end

	always_ff @(posedge clk)
	begin
		if (start_i)
			value_q	<= {{(`FPU_INT_DW-1){1'b0}}, cmp_bit};
	end

	assign res_o = '{valid: valid_q, value: value_q};

endmodule

// File: design/fpu_f2i.sv
// saturates out-of-range and NaN inputs, no inexact or invalid flag is reported
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_f2i
(
	input	logic					clk,
	input	logic					rst,
	input	logic					start_i,
	input	fpu_pkg::rnd_mode_t		rnd_mode_i,
	input	fpu_pkg::operand_t		op_i,
	output	fpu_pkg::unit_res_t		res_o
);

	// fixed point with the full significand width below the integer lsb
	localparam int FIX_FW	= `FPU_FRAC_DW + 1;
	localparam int FIX_DW	= `FPU_INT_DW + FIX_FW;
	localparam int EXT_DW	= `FPU_INT_DW + `FPU_F2I_GUARD;

	localparam fpu_pkg::int_t INT_MAX = {1'b0, {(`FPU_INT_DW-1){1'b1}}};
	localparam fpu_pkg::int_t INT_MIN = {1'b1, {(`FPU_INT_DW-1){1'b0}}};

	fpu_pkg::exp_t			shamt;
	logic	[FIX_DW-1:0]	fix;
	logic	[EXT_DW-1:0]	ext;
	fpu_pkg::int_t			mag;
	fpu_pkg::int_t			mag_rnd;
	fpu_pkg::int_t			conv;
	logic					round_up;
	logic					is_big;
	logic					is_small;
	logic					valid_q;
	fpu_pkg::int_t			value_q;

	//////////////////////////////
	// shift and round
	//////////////////////////////

	always_comb
	begin
		// 0 for values in [0.5,1), 31 for [2^30,2^31)
		shamt		= op_i.exp - fpu_pkg::exp_t'(`FPU_EXP_BIAS - 1);
		fix			= {{(FIX_DW-FIX_FW){1'b0}}, 1'b1, op_i.frac} << shamt;
		// keep guard and round, fold the rest into sticky
		ext			= {fix[FIX_DW-1 -: `FPU_INT_DW], fix[FIX_FW-1], fix[FIX_FW-2],
						|fix[FIX_FW-3:0]};
		mag			= ext[EXT_DW-1 -: `FPU_INT_DW];
		round_up	= (rnd_mode_i == fpu_pkg::FPU_RNDMODE_NEAREST) & ext[2]
						& (ext[1] | ext[0] | mag[0]);
		// no carry out possible, rounding only happens below 2^7
		mag_rnd		= mag + fpu_pkg::int_t'(round_up);
	end

	//////////////////////////////
	// specials and sign
	//////////////////////////////

	always_comb
	begin
		is_big		= (op_i.exp >= fpu_pkg::exp_t'(`FPU_EXP_BIAS + `FPU_INT_DW - 1));
		is_small	= (op_i.exp < fpu_pkg::exp_t'(`FPU_EXP_BIAS - 1));
		if (op_i.is_snan | op_i.is_qnan)
			conv	= INT_MAX;
		else if (is_big | op_i.is_inf)
			conv	= op_i.sign ? INT_MIN : INT_MAX;
		else if (is_small | op_i.is_zero | op_i.is_dn)
			// below one half both modes give zero
			conv	= '0;
		else if (op_i.sign)
			conv	= ~mag_rnd + 1'b1;
		else
			conv	= mag_rnd;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_q	<= 1'b0;
		else
			valid_q	<= start_i;
	end

	always_ff @(posedge clk)
	begin
		if (start_i)
			value_q	<= conv;
	end

	assign res_o = '{valid: valid_q, value: value_q};

endmodule

// File: design/fpu_ctrl.sv
// one operation in flight; a flush only cancels a request seen in IDLE, not one already started
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_ctrl
(
	input	logic					clk,
	input	logic					rst,
	input	logic					flush_i,
	input	logic					padv_i,
	input	fpu_pkg::opcode_t		opcode_i,
	input	fpu_pkg::rnd_mode_t		rnd_mode_i,
	input	fpu_pkg::unit_res_t		cmp_res_i,
	input	fpu_pkg::unit_res_t		f2i_res_i,
	output	logic					cmp_start_o,
	output	logic					f2i_start_o,
	output	fpu_pkg::opcode_t		cmp_opcode_o,
	output	fpu_pkg::rnd_mode_t		rnd_mode_o,
	output	fpu_pkg::int_t			result_o,
	output	logic					result_valid_o,
	output	logic					ready_o
);

	typedef enum logic [1:0]
	{
		IDLE	= 2'd0,
		WORK	= 2'd1,
		DONE	= 2'd2
	} state_t;

	state_t					state_q, state_d;
	fpu_pkg::opcode_t		opcode_q, opcode_d;
	fpu_pkg::rnd_mode_t		rnd_q, rnd_d;
	logic					cmp_start_d;
	logic					f2i_start_d;
	fpu_pkg::int_t			result_d;
	logic					result_valid_d;
	fpu_pkg::unit_res_t		sel_res;

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb
	begin
		state_d			= state_q;
		opcode_d		= opcode_q;
		rnd_d			= rnd_q;
		cmp_start_d		= 1'b0;
		f2i_start_d		= 1'b0;
		result_d		= result_o;
		result_valid_d	= result_valid_o;
		// result of the unit that was started
		sel_res			= (opcode_q == fpu_pkg::FPU_F2I) ? f2i_res_i : cmp_res_i;

		case (state_q)
			IDLE:
			begin
				// flushed requests are dropped here and never start a unit
				if (opcode_i != fpu_pkg::FPU_IDLE && !flush_i)
				begin
					state_d		= WORK;
					opcode_d	= opcode_i;
					rnd_d		= rnd_mode_i;
					if (opcode_i == fpu_pkg::FPU_F2I)
						f2i_start_d	= 1'b1;
					else
						cmp_start_d	= 1'b1;
				end
			end
			WORK:
			begin
				if (sel_res.valid)
				begin
					result_d		= sel_res.value;
					result_valid_d	= 1'b1;
					state_d			= DONE;
				end
			end
			DONE:
			begin
				// hold the result until the pipeline advances
				if (padv_i)
				begin
					result_valid_d	= 1'b0;
					state_d			= IDLE;
				end
			end
			default:
				state_d	= IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q			<= IDLE;
			opcode_q		<= fpu_pkg::FPU_IDLE;
			rnd_q			<= fpu_pkg::FPU_RNDMODE_NEAREST;
			cmp_start_o		<= 1'b0;
			f2i_start_o		<= 1'b0;
			result_o		<= '0;
			result_valid_o	<= 1'b0;
		end
		else
		begin
			state_q			<= state_d;
			opcode_q		<= opcode_d;
			rnd_q			<= rnd_d;
			cmp_start_o		<= cmp_start_d;
			f2i_start_o		<= f2i_start_d;
			result_o		<= result_d;
			result_valid_o	<= result_valid_d;
		end
	end

	assign cmp_opcode_o	= opcode_q;
	assign rnd_mode_o	= rnd_q;
	assign ready_o		= (opcode_i == fpu_pkg::FPU_IDLE) | result_valid_o;

endmodule

// File: design/fpu_top.sv
// only op1_i[15:0] is used as a float; fixed two-cycle latency from acceptance to result_valid_o
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_top
(
	input	logic					clk,
	input	logic					rst,
	input	logic					flush_i,
	input	logic					padv_i,
	input	fpu_pkg::opcode_t		opcode_i,
	input	fpu_pkg::rnd_mode_t		rnd_mode_i,
	input	fpu_pkg::int_t			op1_i,
	input	fpu_pkg::float_t		op2_i,
	output	fpu_pkg::int_t			result_o,
	output	logic					result_valid_o,
	output	logic					ready_o
);

	fpu_pkg::operand_t		op1_operand;
	fpu_pkg::operand_t		op2_operand;
	fpu_pkg::unit_res_t		cmp_res;
	fpu_pkg::unit_res_t		f2i_res;
	fpu_pkg::opcode_t		cmp_opcode;
	fpu_pkg::rnd_mode_t		rnd_mode;
	logic					cmp_start;
	logic					f2i_start;

	fpu_operand_unpack fpu_operand_unpack0
	(
		.clk			(clk),
		.rst			(rst),
		.op1_i			(op1_i[`FPU_FLOAT_DW-1:0]),
		.op2_i			(op2_i),
		.op1_operand_o	(op1_operand),
		.op2_operand_o	(op2_operand)
	);

	fpu_cmp fpu_cmp0
	(
		.clk			(clk),
		.rst			(rst),
		.start_i		(cmp_start),
		.opcode_i		(cmp_opcode),
		.op1_i			(op1_operand),
		.op2_i			(op2_operand),
		.res_o			(cmp_res)
	);

	// conversion always works on the first operand
	fpu_f2i fpu_f2i0
	(
		.clk			(clk),
		.rst			(rst),
		.start_i		(f2i_start),
		.rnd_mode_i		(rnd_mode),
		.op_i			(op1_operand),
		.res_o			(f2i_res)
	);

	fpu_ctrl fpu_ctrl0
	(
		.clk			(clk),
		.rst			(rst),
		.flush_i		(flush_i),
		.padv_i			(padv_i),
		.opcode_i		(opcode_i),
		.rnd_mode_i		(rnd_mode_i),
		.cmp_res_i		(cmp_res),
		.f2i_res_i		(f2i_res),
		.cmp_start_o	(cmp_start),
		.f2i_start_o	(f2i_start),
		.cmp_opcode_o	(cmp_opcode),
		.rnd_mode_o		(rnd_mode),
		.result_o		(result_o),
		.result_valid_o	(result_valid_o),
		.ready_o		(ready_o)
	);

endmodule

// File: bench/fpu_props.sv
// sampled on the rising edge; inputs are expected to change only away from that edge
`timescale 1ns/1ps

module fpu_props
(
	input	logic				clk,
	input	logic				rst,
	input	logic				flush_i,
	input	logic				padv_i,
	input	fpu_pkg::opcode_t	opcode_i,
	input	fpu_pkg::int_t		result_i,
	input	logic				result_valid_i,
	input	logic				ready_i
);

	logic	busy_q;
	logic	accept;

	// request taken while nothing is in flight
	assign accept = !rst && !busy_q && (opcode_i != fpu_pkg::FPU_IDLE) && !flush_i;

	always_ff @(posedge clk)
	begin
		if (rst)
			busy_q	<= 1'b0;
		else if (accept)
			busy_q	<= 1'b1;
		else if (result_valid_i && padv_i)
			busy_q	<= 1'b0;
	end

	//////////////////////////////
	// handshake
	//////////////////////////////

	reset_quiet: assert property (@(posedge clk) $past(rst) |-> !result_valid_i)
		else $error("result_valid_o high during reset");

	result_held: assert property (@(posedge clk) disable iff (rst)
		$past(result_valid_i && !padv_i) |-> result_valid_i && (result_i == $past(result_i)))
		else $error("result changed before the pipeline advanced");

	// rises at the second edge after acceptance, seen one sample later
	two_cycle_latency: assert property (@(posedge clk) disable iff (rst)
		$rose(result_valid_i) == $past(accept, 3))
		else $error("result_valid_o did not rise two cycles after acceptance");

	ready_rule: assert property (@(posedge clk) disable iff (rst)
		ready_i == ((opcode_i == fpu_pkg::FPU_IDLE) || result_valid_i))
		else $error("ready_o does not follow opcode_i and result_valid_o");

endmodule

bind fpu_top fpu_props props0
(
	.clk			(clk),
	.rst			(rst),
	.flush_i		(flush_i),
	.padv_i			(padv_i),
	.opcode_i		(opcode_i),
	.result_i		(result_o),
	.result_valid_i	(result_valid_o),
	.ready_i		(ready_o)
);

// File: bench/fpu_tb.sv
// drives one request at a time and holds it until the result; stops at the first failing check
`timescale 1ns/1ps

module fpu_tb;

	localparam int OP_BUDGET		= 400;
	localparam int CYCLES_PER_OP	= 6;
	localparam int TIMEOUT_CYCLES	= OP_BUDGET * CYCLES_PER_OP;

	logic					clk = 1'b0;
	logic					rst;
	logic					flush_i;
	logic					padv_i;
	fpu_pkg::opcode_t		opcode_i;
	fpu_pkg::rnd_mode_t		rnd_mode_i;
	fpu_pkg::int_t			op1_i;
	fpu_pkg::float_t		op2_i;
	fpu_pkg::int_t			result_o;
	logic					result_valid_o;
	logic					ready_o;
	integer					seed;
	int						cycle_count = 0;

	// op1 in the upper half, op2 in the lower half
	logic	[31:0]		cmp_pairs [12] = '{32'h0000_8000, 32'h8000_0000, 32'h3fc0_3fc0,
							32'h3f80_4000, 32'hbf80_3f80, 32'hc000_bf80, 32'h7f80_7f7f,
							32'hff80_7f80, 32'h7f80_7f80, 32'h7fc0_3f80, 32'h7f81_7f81,
							32'h0001_0000};
	// halfway values, range limits, specials, denormal and zero
	fpu_pkg::float_t	f2i_values [15] = '{16'h4020, 16'h4060, 16'hc020, 16'hbfc0,
							16'h3f00, 16'h3f80, 16'h4eff, 16'h4f00, 16'hcf00, 16'h7f80,
							16'hff80, 16'h7fc0, 16'hff81, 16'h0040, 16'h8000};

	fpu_top dut0
	(
		.clk			(clk),
		.rst			(rst),
		.flush_i		(flush_i),
		.padv_i			(padv_i),
		.opcode_i		(opcode_i),
		.rnd_mode_i		(rnd_mode_i),
		.op1_i			(op1_i),
		.op2_i			(op2_i),
		.result_o		(result_o),
		.result_valid_o	(result_valid_o),
		.ready_o		(ready_o)
	);

	always #10 clk = ~clk;

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic bit is_nan(input fpu_pkg::float_t f);
		return (f[14:7] == 8'hff) && (f[6:0] != 7'd0);
	endfunction

	// signed magnitude key orders all non-NaN values, both zeros map to 0
	function automatic fpu_pkg::int_t cmp_model(input fpu_pkg::opcode_t op,
			input fpu_pkg::float_t a, input fpu_pkg::float_t b);
		int	ka;
		int	kb;
		bit	r;
		if (is_nan(a) || is_nan(b))
			return '0;
		ka = a[15] ? -int'(a[14:0]) : int'(a[14:0]);
		kb = b[15] ? -int'(b[14:0]) : int'(b[14:0]);
		case (op)
			fpu_pkg::FPU_EQ:	r = (ka == kb);
			fpu_pkg::FPU_LT:	r = (ka < kb);
			fpu_pkg::FPU_LE:	r = (ka <= kb);
			default:			r = 1'b0;
		endcase
		return fpu_pkg::int_t'(r);
	endfunction

	// value is sig * 2^(e - 134)
	function automatic fpu_pkg::int_t f2i_model(input fpu_pkg::float_t f,
			input fpu_pkg::rnd_mode_t mode);
		int		e;
		int		s;
		longint	sig;
		longint	q;
		longint	rem;
		longint	half;
		e	= f[14:7];
		sig	= {1'b1, f[6:0]};
		if (is_nan(f))
			return 32'h7fffffff;
		if (e == 255 || e >= 127 + 31)
			return f[15] ? 32'h80000000 : 32'h7fffffff;
		if (e == 0)
			return '0;
		if (e >= 134)
			q = sig << (e - 134);
		else
		begin
			s = 134 - e;
			q = (s > 40) ? 0 : (sig >> s);
			rem = (s > 40) ? sig : sig - (q << s);
			half = (s > 40) ? 512 : (longint'(1) << (s - 1));
			if (mode == fpu_pkg::FPU_RNDMODE_NEAREST && (rem > half || (rem == half && q[0])))
				q = q + 1;
		end
		if (f[15])
			q = -q;
		return q[31:0];
	endfunction

	// exponent kept near the integer range when in_range is set
	function automatic fpu_pkg::float_t random_float(input logic in_range);
		logic	[31:0]	r;
		logic	[7:0]	e;
		r = $random(seed);
		e = 8'd118 + 8'(r[15:8] % 8'd42);
		return in_range ? {r[16], e, r[6:0]} : r[15:0];
	endfunction

	//////////////////////////////
	// checks and stimulus
	//////////////////////////////

	task automatic fail_now();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic expect_equal(input string name, input fpu_pkg::int_t expected,
			input fpu_pkg::int_t actual);
		assert (actual == expected)
		else
		begin
			$display("error %s expected %h actual %h", name, expected, actual);
			fail_now();
		end
	endtask

	task automatic require_true(input bit cond, input string what);
		assert (cond)
		else
		begin
			$display("%s", what);
			fail_now();
		end
	endtask

	// request stays on opcode_i until the result is taken
	task automatic issue_op(input fpu_pkg::opcode_t op, input fpu_pkg::rnd_mode_t rnd,
			input fpu_pkg::int_t a, input fpu_pkg::float_t b, input int hold);
		fpu_pkg::int_t	expected;
		int				wait_cycles;
		if (op == fpu_pkg::FPU_F2I)
			expected = f2i_model(a[15:0], rnd);
		else
			expected = cmp_model(op, a[15:0], b);
		wait_cycles	= 0;
		opcode_i	= op;
		rnd_mode_i	= rnd;
		op1_i		= a;
		op2_i		= b;
		padv_i		= 1'b0;
		@(negedge clk);
		while (!result_valid_o && wait_cycles < 8)
		begin
			require_true(!ready_o, "ready_o was high while a request was pending");
			wait_cycles++;
			@(negedge clk);
		end
		require_true(result_valid_o, "no result arrived after an accepted request");
		require_true(wait_cycles == 2, "result did not arrive two cycles after acceptance");
		expect_equal("result_o", expected, result_o);
		expect_equal("ready_o", 1, ready_o);
		repeat (hold)
		begin
			@(negedge clk);
			expect_equal("result_valid_o", 1, result_valid_o);
			expect_equal("result_o", expected, result_o);
		end
		padv_i		= 1'b1;
		opcode_i	= fpu_pkg::FPU_IDLE;
		@(negedge clk);
		padv_i		= 1'b0;
		expect_equal("result_valid_o", 0, result_valid_o);
	endtask

	task automatic cmp_three_ways(input fpu_pkg::float_t a, input fpu_pkg::float_t b);
		for (int k = 1; k <= 3; k++)
			issue_op(fpu_pkg::opcode_t'(k), fpu_pkg::FPU_RNDMODE_NEAREST, {16'h0, a}, b, 0);
	endtask

	// upper half of op1 filled with junk, only the low word is a float
	task automatic convert_both_modes(input fpu_pkg::float_t f);
		issue_op(fpu_pkg::FPU_F2I, fpu_pkg::FPU_RNDMODE_NEAREST, {~f, f}, 16'h0, 0);
		issue_op(fpu_pkg::FPU_F2I, fpu_pkg::FPU_RNDMODE_TRUNCATE, {~f, f}, 16'h0, 0);
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			fail_now();
		end
	end

	initial
	begin
		fpu_pkg::float_t	a;
		fpu_pkg::float_t	b;
		logic	[31:0]		r;
		int					k;
		seed		= 32'h6bbfa16e;
		rst			= 1'b1;
		flush_i		= 1'b0;
		padv_i		= 1'b0;
		opcode_i	= fpu_pkg::FPU_IDLE;
		rnd_mode_i	= fpu_pkg::FPU_RNDMODE_NEAREST;
		op1_i		= '0;
		op2_i		= '0;
		repeat (16) @(negedge clk);
		rst			= 1'b0;
		@(negedge clk);
		expect_equal("result_valid_o", 0, result_valid_o);
		expect_equal("ready_o", 1, ready_o);

		foreach (cmp_pairs[i])
			cmp_three_ways(cmp_pairs[i][31:16], cmp_pairs[i][15:0]);
		// one compare per pair, a quarter of them on equal values
		repeat (200)
		begin
			r = $random(seed);
			k = 1 + r[7:4] % 3;
			a = random_float(r[0]);
			b = (r[3:2] == 2'd0) ? a : random_float(r[1]);
			issue_op(fpu_pkg::opcode_t'(k), fpu_pkg::FPU_RNDMODE_NEAREST, {r[31:16], a}, b, 0);
		end

		foreach (f2i_values[i])
			convert_both_modes(f2i_values[i]);
		repeat (80)
		begin
			r = $random(seed);
			a = random_float(r[0]);
			issue_op(fpu_pkg::FPU_F2I, fpu_pkg::rnd_mode_t'(r[1]), {r[31:16], a}, 16'h0, 0);
		end

		// flushed request is dropped
		opcode_i	= fpu_pkg::FPU_EQ;
		op1_i		= 32'h3f80;
		op2_i		= 16'h3f80;
		flush_i		= 1'b1;
		@(negedge clk);
		flush_i		= 1'b0;
		opcode_i	= fpu_pkg::FPU_IDLE;
		repeat (5)
		begin
			@(negedge clk);
			expect_equal("result_valid_o", 0, result_valid_o);
		end
		issue_op(fpu_pkg::FPU_EQ, fpu_pkg::FPU_RNDMODE_NEAREST, 32'h3f80, 16'h3f80, 0);

		// back-pressure with random padv_i stretches
		repeat (40)
		begin
			r = $random(seed);
			k = 1 + r[7:4] % 4;
			a = random_float(r[0]);
			b = random_float(r[2]);
			issue_op(fpu_pkg::opcode_t'(k), fpu_pkg::rnd_mode_t'(r[1]), {r[31:16], a}, b,
				r[11:8] % 7);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: src.f
+incdir+design
design/fpu_pkg.sv
design/fpu_operand_unpack.sv
design/fpu_cmp.sv
design/fpu_f2i.sv
design/fpu_ctrl.sv
design/fpu_top.sv
bench/fpu_props.sv
bench/fpu_tb.sv

// File: run.sh
#!/bin/sh
# builds the bfloat16 FPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module fpu_tb \
	-Mdir obj_dir -o fpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/fpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
